// ==== tb/switch_alloc_patterns.txt ====
# vld | hop N S W E L | flit N S W E L | adv | grant N S W E L | out_vld | out_flit N S W E L
# All fields hex; vectors have bit 0 = N, then S, W, E, L. Codes: N=0 S=1 W=2 E=3 L=4.
00 0 0 0 0 0 1000 2000 3000 4000 5000 00 00 00 00 00 00 00 0000 0000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 00 00 01 00 00 00 02 0000 1000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 01 00 00 00 02 0000 1000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 04 00 00 00 02 0000 3000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 08 00 00 00 02 0000 4000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 10 00 00 00 02 0000 5000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 01 00 00 00 02 0000 1000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 00 00 04 00 00 00 02 0000 3000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 00 00 04 00 00 00 02 0000 3000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 00 00 04 00 00 00 02 0000 3000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 04 00 00 00 02 0000 3000 0000 0000 0000
0f 0 5 7 3 2 1000 2000 3000 4000 5000 00 00 00 00 00 00 00 0000 0000 0000 0000 0000
1f 3 2 0 4 1 aaaa bbbb cccc dddd eeee 01 04 10 02 01 08 1f cccc eeee bbbb aaaa dddd
00 0 0 0 0 0 1000 2000 3000 4000 5000 1f 00 00 00 00 00 00 0000 0000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 02 00 08 00 00 00 02 0000 4000 0000 0000 0000
1d 1 0 1 1 1 1000 2000 3000 4000 5000 00 00 10 00 00 00 02 0000 5000 0000 0000 0000
1e 0 0 0 0 0 1000 2000 3000 4000 5000 01 08 00 00 00 00 01 4000 0000 0000 0000 0000
1e 0 0 0 0 0 1000 2000 3000 4000 5000 00 10 00 00 00 00 01 5000 0000 0000 0000 0000
00 0 0 0 0 0 1000 2000 3000 4000 5000 00 00 00 00 00 00 00 0000 0000 0000 0000 0000

// ==== all.f ====
design/noc_port_pkg.sv
design/noc_arb_pkg.sv
design/route_decoder.sv
design/output_arbiter.sv
design/output_switch.sv
design/switch_allocator.sv
tb/tb_switch_allocator.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the switch allocator testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

TOP=tb_switch_allocator
LOG=sim.log

verilator --binary --assert --top-module "$TOP" -Mdir obj_dir -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "Finished with errors" "$LOG" || grep -q "TIMEOUT" "$LOG"; then
    echo "Simulation failed, see $LOG."
    exit 1
fi

echo "Simulation passed."
exit 0

// ==== tb/tb_switch_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_switch_allocator
        import noc_port_pkg::*;
        import noc_arb_pkg::*;
();

        localparam int    FLIT_W       = 16;
        localparam int    CLK_PERIOD   = 4;
        localparam int    RESET_CYCLES = 3;
        localparam int    MAX_PAT      = 64;
        localparam int    FIELDS       = 23;
        localparam string PATTERN_FILE = "tb/switch_alloc_patterns.txt";

        logic                             clk;
        logic                             rst_n_i;
        logic       [NUM_PORTS-1:0]             valid_i;
        port_code_t [NUM_PORTS-1:0]             nexthop_i;
        logic       [NUM_PORTS-1:0][FLIT_W-1:0] flit_i;
        logic       [NUM_PORTS-1:0]             advance_i;
        port_vec_t  [NUM_PORTS-1:0]             grant_o;
        logic       [NUM_PORTS-1:0]             out_valid_o;
        logic       [NUM_PORTS-1:0][FLIT_W-1:0] out_flit_o;

        // One entry per pattern line, stimulus first, then the expected results.
        logic       [NUM_PORTS-1:0]             pat_valid [MAX_PAT];
        port_code_t [NUM_PORTS-1:0]             pat_hop   [MAX_PAT];
        logic       [NUM_PORTS-1:0][FLIT_W-1:0] pat_flit  [MAX_PAT];
        logic       [NUM_PORTS-1:0]             pat_adv   [MAX_PAT];
        port_vec_t  [NUM_PORTS-1:0]             exp_grant [MAX_PAT];
        logic       [NUM_PORTS-1:0]             exp_valid [MAX_PAT];
        logic       [NUM_PORTS-1:0][FLIT_W-1:0] exp_flit  [MAX_PAT];

        int n_pat        = 0;
        int cur_pat      = 0;
        int check_errors = 0;
        int file_errors  = 0;
        int cycles       = 0;
        int cycle_limit  = 0;   // Zero until the patterns are loaded.

        switch_allocator #(
                .FLIT_W (FLIT_W)
        ) uut (
                .clk         (clk),
                .rst_n_i     (rst_n_i),
                .valid_i     (valid_i),
                .nexthop_i   (nexthop_i),
                .flit_i      (flit_i),
                .advance_i   (advance_i),
                .grant_o     (grant_o),
                .out_valid_o (out_valid_o),
                .out_flit_o  (out_flit_o)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycle_limit != 0 && cycles >= cycle_limit) begin
                        $display("TIMEOUT: the pattern run did not end within %0d cycles.",
                                 cycle_limit);
                        $display("Errors: %0d check failures, %0d file problems",
                                 check_errors, file_errors);
                        $display("Finished with errors");
                        $finish;
                end
        end

        task automatic check_grant(input int k, input port_vec_t expected,
                                   input port_vec_t actual);
                if (actual !== expected) begin
                        check_errors++;
                        $display(
                                "CHECK FAILED at %0t pat %0d: grant_o[%0d] expected %b, got %b",
                                $time, cur_pat, k, expected, actual);
                end
        endtask

        task automatic check_valid(input logic [NUM_PORTS-1:0] expected,
                                   input logic [NUM_PORTS-1:0] actual);
                if (actual !== expected) begin
                        check_errors++;
                        $display(
                                "CHECK FAILED at %0t pat %0d: out_valid_o expected %b, got %b",
                                $time, cur_pat, expected, actual);
                end
        endtask

        task automatic check_flit(input int k, input logic [FLIT_W-1:0] expected,
                                  input logic [FLIT_W-1:0] actual);
                if (actual !== expected) begin
                        check_errors++;
                        $display(
                                "CHECK FAILED at %0t pat %0d: out_flit_o[%0d] expected %h, got %h",
                                $time, cur_pat, k, expected, actual);
                end
        endtask

        task automatic load_patterns();
                int          fd;
                int          got;
                int          line_no;
                string       line;
                logic [31:0] f [FIELDS];
                fd = $fopen(PATTERN_FILE, "r");
                if (fd == 0) begin
                        $display("Cannot open the pattern file %s.", PATTERN_FILE);
                        file_errors++;
                        return;
                end
                line_no = 0;
                while ($fgets(line, fd) != 0) begin
                        line_no++;
                        if (line.len() < 2 || line.getc(0) == "#") begin
                                continue;       // Blank line or column notes.
                        end
                        got = $sscanf(line,
                                "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15],
                                f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
                        if (got != FIELDS) begin
                                $display("Malformed pattern line %0d, %0d of %0d fields read.",
                                         line_no, got, FIELDS);
                                file_errors++;
                                continue;
                        end
                        if (n_pat == MAX_PAT) begin
                                $display("More than %0d patterns in the pattern file.", MAX_PAT);
                                file_errors++;
                                break;
                        end
                        pat_valid[n_pat] = f[0][NUM_PORTS-1:0];
                        pat_adv[n_pat]   = f[11][NUM_PORTS-1:0];
                        exp_valid[n_pat] = f[17][NUM_PORTS-1:0];
                        for (int i = 0; i < NUM_PORTS; i++) begin
                                pat_hop[n_pat][i]   = f[1 + i][2:0];
                                pat_flit[n_pat][i]  = f[6 + i][FLIT_W-1:0];
                                exp_grant[n_pat][i] = f[12 + i][NUM_PORTS-1:0];
                                exp_flit[n_pat][i]  = f[18 + i][FLIT_W-1:0];
                        end
                        n_pat++;
                end
                $fclose(fd);
                if (n_pat == 0) begin
                        $display("The pattern file holds no patterns.");
                        file_errors++;
                end
        endtask

        initial begin
                rst_n_i   = 1'b0;
                valid_i   = '0;
                nexthop_i = '0;
                flit_i    = '0;
                advance_i = '0;

                load_patterns();
                cycle_limit = n_pat + RESET_CYCLES + 20;

                repeat (RESET_CYCLES) @(posedge clk);
                rst_n_i <= 1'b1;

                for (int n = 0; n < n_pat; n++) begin
                        @(posedge clk);
                        cur_pat = n;
                        valid_i   <= pat_valid[n];
                        nexthop_i <= pat_hop[n];
                        flit_i    <= pat_flit[n];
                        advance_i <= pat_adv[n];
                        // Results are combinational, so they settle well before the next edge.
                        #(CLK_PERIOD - 1);
                        for (int k = 0; k < NUM_PORTS; k++) begin
                                check_grant(k, exp_grant[n][k], grant_o[k]);
                                check_flit(k, exp_flit[n][k], out_flit_o[k]);
                        end
                        check_valid(exp_valid[n], out_valid_o);
                end

                $display("Errors: %0d check failures, %0d file problems",
                         check_errors, file_errors);
                if (check_errors == 0 && file_errors == 0) begin
                        $display("Finished with no errors");
                end else begin
                        $display("Finished with errors");
                end
                $finish;
        end

endmodule : tb_switch_allocator

`default_nettype wire

// ==== design/switch_allocator.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_allocator
        import noc_port_pkg::*;
        import noc_arb_pkg::*;
#(
        parameter int FLIT_W = 16
) (
        input  logic                                   clk,
        input  logic                                   rst_n_i,
        input  logic       [NUM_PORTS-1:0]             valid_i,
        input  port_code_t [NUM_PORTS-1:0]             nexthop_i,
        input  logic       [NUM_PORTS-1:0][FLIT_W-1:0] flit_i,
        input  logic       [NUM_PORTS-1:0]             advance_i,  // One strobe per output.
        output port_vec_t  [NUM_PORTS-1:0]             grant_o,
        output logic       [NUM_PORTS-1:0]             out_valid_o,
        output logic       [NUM_PORTS-1:0][FLIT_W-1:0] out_flit_o
);

        port_vec_t [NUM_PORTS-1:0] req;    // Row k holds the requests for output k.
        port_vec_t [NUM_PORTS-1:0] grant;

        // Decode.
        route_decoder u_route_decoder (
                .valid_i   (valid_i),
                .nexthop_i (nexthop_i),
                .req_o     (req)
        );

        // Execute. Each output keeps its own pointer and advance strobe.
        for (genvar k = 0; k < NUM_PORTS; k++) begin : g_arb
                output_arbiter u_output_arbiter (
                        .clk       (clk),
                        .rst_n_i   (rst_n_i),
                        .req_i     (req[k]),
                        .advance_i (advance_i[k]),
                        .grant_o   (grant[k])
                );
        end

        // Result.
        output_switch #(
                .FLIT_W (FLIT_W)
        ) u_output_switch (
                .grant_i     (grant),
                .flit_i      (flit_i),
                .out_valid_o (out_valid_o),
                .out_flit_o  (out_flit_o)
        );

        assign grant_o = grant;

endmodule : switch_allocator

`default_nettype wire

// ==== design/output_switch.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_switch
        import noc_port_pkg::*;
        import noc_arb_pkg::*;
#(
        parameter int FLIT_W = 16
) (
        input  port_vec_t [NUM_PORTS-1:0]              grant_i,
        input  logic      [NUM_PORTS-1:0][FLIT_W-1:0]  flit_i,
        output logic      [NUM_PORTS-1:0]              out_valid_o,
        output logic      [NUM_PORTS-1:0][FLIT_W-1:0]  out_flit_o
);

        // Grants are one-hot or zero, so an AND-OR mux picks the winner's
        // flit and yields zero on an idle output.
        always_comb begin
                for (int k = 0; k < NUM_PORTS; k++) begin
                        out_valid_o[k] = |grant_i[k];
                        out_flit_o[k]  = '0;
                        for (int j = 0; j < NUM_PORTS; j++) begin
                                out_flit_o[k] = out_flit_o[k] |
                                                ({FLIT_W{grant_i[k][j]}} & flit_i[j]);
                        end
                end
        end

endmodule : output_switch

`default_nettype wire

// ==== design/output_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module output_arbiter
        import noc_port_pkg::*;
        import noc_arb_pkg::*;
(
        input  logic      clk,
        input  logic      rst_n_i,
        input  port_vec_t req_i,
        input  logic      advance_i,
        output port_vec_t grant_o
);

        localparam port_vec_t PTR_RST = port_vec_t'(1) << PORT_N;

        port_vec_t                ptr_q;   // One-hot marker of the input searched first.
        logic [2*NUM_PORTS-1:0]   req_dbl;
        logic [2*NUM_PORTS-1:0]   ptr_dbl;
        logic [2*NUM_PORTS-1:0]   gnt_dbl;

        // Two copies of the requests side by side make the cyclic search a
        // plain upward search that starts at the pointer.
        assign req_dbl = {req_i, req_i};
        assign ptr_dbl = {{NUM_PORTS{1'b0}}, ptr_q};

        // Subtracting the pointer borrows up to the first request at or
        // above it and clears that bit; masking against the requests keeps
        // exactly that one bit.
        assign gnt_dbl = req_dbl & ~(req_dbl - ptr_dbl);

        // A winner below the pointer shows up in the upper copy.
        assign grant_o = gnt_dbl[NUM_PORTS-1:0] | gnt_dbl[2*NUM_PORTS-1:NUM_PORTS];

        always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                        ptr_q <= PTR_RST;
                end else if (advance_i && (|grant_o)) begin
                        // Rotate past the winner so that L wraps to N.
                        ptr_q <= {grant_o[NUM_PORTS-2:0], grant_o[NUM_PORTS-1]};
                end
        end

        a_ptr_onehot: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                $onehot(ptr_q)
        ) else $error("output_arbiter: pointer is not one-hot");

        a_grant_onehot0: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                $onehot0(grant_o)
        ) else $error("output_arbiter: more than one input granted");

        a_grant_in_req: assert property (
                @(posedge clk) disable iff (!rst_n_i)
                (grant_o & ~req_i) == '0
        ) else $error("output_arbiter: grant without a request");

endmodule : output_arbiter

`default_nettype wire

// ==== design/route_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module route_decoder
        import noc_port_pkg::*;
        import noc_arb_pkg::*;
(
        input  port_vec_t                   valid_i,
        input  port_code_t [NUM_PORTS-1:0]  nexthop_i,
        output port_vec_t  [NUM_PORTS-1:0]  req_o
);

        // One row per output; bit j of row k is set when input j wants output k.
        always_comb begin
                for (int k = 0; k < NUM_PORTS; k++) begin
                        for (int j = 0; j < NUM_PORTS; j++) begin
                                req_o[k][j] = valid_i[j] &&
                                              (nexthop_i[j] <= PORT_L) &&
                                              (nexthop_i[j] == port_code_t'(k)) &&
                                              (j != k); // No U-turns.
                        end
                end
        end

        // The arbiters rely on never seeing a self-request, since the switch
        // would otherwise loop a flit back out of the port it entered by.
        always_comb begin
                for (int k = 0; k < NUM_PORTS; k++) begin
                        assert (!req_o[k][k])
                                else $error("route_decoder: self-request on port %0d", k);
                end
        end

endmodule : route_decoder

`default_nettype wire

// ==== design/noc_arb_pkg.sv ====
`default_nettype none

package noc_arb_pkg;

        import noc_port_pkg::*;

        // One bit per input port, indexed N, S, W, E, L from bit 0.
        // The same shape carries three things between the allocator stages:
        //   a request vector, where any number of bits may be set,
        //   a grant, which is one-hot or zero,
        //   a round-robin pointer, which is always one-hot.
        typedef logic [NUM_PORTS-1:0] port_vec_t;

endpackage : noc_arb_pkg

`default_nettype wire

// ==== design/noc_port_pkg.sv ====
`default_nettype none

package noc_port_pkg;

        // Five router ports: north, south, west, east and local.
        localparam int NUM_PORTS = 5;

        // Next-hop code that each input presents with its flit.
        typedef logic [2:0] port_code_t;

        // The codes also serve as port indices, so a code selects the
        // output port of the same number.
        localparam port_code_t PORT_N = 3'd0;
        localparam port_code_t PORT_S = 3'd1;
        localparam port_code_t PORT_W = 3'd2;
        localparam port_code_t PORT_E = 3'd3;
        localparam port_code_t PORT_L = 3'd4;

        // Codes 5 to 7 are unused and request no port at all.

endpackage : noc_port_pkg

`default_nettype wire
